// ==== hdl/trace_pkg.sv ====
// RV32I base opcodes only; compressed, FP and custom-extension encodings all classify as invalid
`default_nettype none

package trace_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int class_w    = 4;
  localparam int cycle_w    = 32;

  //////////////////////////////
  // base opcodes
  //////////////////////////////
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_fence  = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;

  //////////////////////////////
  // class codes
  //////////////////////////////
  localparam logic [class_w-1:0] cls_upper   = 4'd1;
  localparam logic [class_w-1:0] cls_jump    = 4'd2;
  localparam logic [class_w-1:0] cls_branch  = 4'd3;
  localparam logic [class_w-1:0] cls_load    = 4'd4;
  localparam logic [class_w-1:0] cls_store   = 4'd5;
  localparam logic [class_w-1:0] cls_alu_imm = 4'd6;
  localparam logic [class_w-1:0] cls_alu_reg = 4'd7;
  localparam logic [class_w-1:0] cls_fence   = 4'd8;
  localparam logic [class_w-1:0] cls_csr     = 4'd9;
  localparam logic [class_w-1:0] cls_system  = 4'd10;
  localparam logic [class_w-1:0] cls_invalid = 4'd15;

  // register-register layout
  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } instr_r_t;

  // store layout, immediate split around the register fields
  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } instr_s_t;

  typedef union packed {
    instr_r_t r;
    instr_s_t s;
  } instr_word_u;

  function automatic logic class_writes_rd(input logic [class_w-1:0] cls);
    case (cls)
      cls_upper,
      cls_jump,
      cls_load,
      cls_alu_imm,
      cls_alu_reg,
      cls_csr: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic class_is_mem(input logic [class_w-1:0] cls);
    return (cls == cls_load) || (cls == cls_store);
  endfunction

  function automatic logic class_is_store(input logic [class_w-1:0] cls);
    return cls == cls_store;
  endfunction

endpackage

`default_nettype wire

// ==== hdl/trace_capture.sv ====
// accepts only on id_valid with is_decoding high; the cycle stamp wraps after 2**32 cycles
`default_nettype none

module trace_capture (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [trace_pkg::xlen-1:0]       pc,
  input  trace_pkg::instr_word_u           instr,
  input  logic                             id_valid,
  input  logic                             is_decoding,
  output logic                             cap_valid,
  output logic [trace_pkg::xlen-1:0]       cap_pc,
  output trace_pkg::instr_word_u           cap_instr,
  output logic [trace_pkg::class_w-1:0]    cap_class,
  output logic [trace_pkg::reg_addr_w-1:0] cap_rd,
  output logic                             cap_rd_we,
  output logic                             cap_mem,
  output logic                             cap_mem_store,
  output logic [trace_pkg::cycle_w-1:0]    cap_cycle
);

  import trace_pkg::*;

  logic               accept;
  logic [class_w-1:0] cls;
  logic               rd_we;
  logic [cycle_w-1:0] cycle_cnt;

  assign accept = id_valid & is_decoding;

  //////////////////////////////
  // classification
  //////////////////////////////
  always_comb begin
    case (instr.r.opcode)
      opc_lui,
      opc_auipc:  cls = cls_upper;
      opc_jal,
      opc_jalr:   cls = cls_jump;
      opc_branch: cls = cls_branch;
      // lb lh lw lbu lhu only
      opc_load:   cls = (instr.r.funct3 inside {3'd3, 3'd6, 3'd7}) ? cls_invalid : cls_load;
      // sb sh sw only
      opc_store:  cls = (instr.s.funct3 > 3'd2) ? cls_invalid : cls_store;
      opc_op_imm: cls = cls_alu_imm;
      opc_op:     cls = cls_alu_reg;
      opc_fence:  cls = cls_fence;
      // csr access uses a nonzero funct3
      opc_system: cls = (instr.r.funct3 != 3'd0) ? cls_csr : cls_system;
      default:    cls = cls_invalid;
    endcase
  end

  // x0 writes are never reported
  assign rd_we = class_writes_rd(cls) && (instr.r.rd != '0);

  //////////////////////////////
  // cycle counter
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= accept;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (accept) begin
      cap_pc        <= pc;
      cap_instr     <= instr;
      cap_class     <= cls;
      cap_rd        <= instr.r.rd;
      cap_rd_we     <= rd_we;
      cap_mem       <= class_is_mem(cls);
      cap_mem_store <= class_is_store(cls);
      cap_cycle     <= cycle_cnt;
    end
  end

  // the rd field of a store holds imm_lo and must not show up as a write
  a_store_no_rd: assert property (
    @(posedge clk) disable iff (!rst_n)
    accept && class_is_store(cls) && (instr.s.imm_lo != '0) |=> cap_valid && !cap_rd_we
  );

endmodule

`default_nettype wire

// ==== hdl/trace_stage_track.sv ====
// one shadow slot per stage; a decode into a held EX slot or an EX advance into a held WB slot is lost
`default_nettype none

module trace_stage_track (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cap_valid,
  input  logic [trace_pkg::xlen-1:0]       cap_pc,
  input  trace_pkg::instr_word_u           cap_instr,
  input  logic [trace_pkg::class_w-1:0]    cap_class,
  input  logic [trace_pkg::reg_addr_w-1:0] cap_rd,
  input  logic                             cap_rd_we,
  input  logic                             cap_mem,
  input  logic                             cap_mem_store,
  input  logic [trace_pkg::cycle_w-1:0]    cap_cycle,
  input  logic                             ex_valid,
  input  logic [trace_pkg::reg_addr_w-1:0] ex_reg_addr,
  input  logic                             ex_reg_we,
  input  logic [trace_pkg::xlen-1:0]       ex_reg_wdata,
  input  logic                             ex_data_req,
  input  logic                             ex_data_gnt,
  input  logic                             ex_data_we,
  input  logic [trace_pkg::xlen-1:0]       ex_data_addr,
  input  logic                             wb_bypass,
  input  logic                             wb_valid,
  input  logic [trace_pkg::reg_addr_w-1:0] wb_reg_addr,
  input  logic                             wb_reg_we,
  input  logic [trace_pkg::xlen-1:0]       wb_reg_wdata,
  output logic                             done_valid,
  output logic [trace_pkg::xlen-1:0]       done_pc,
  output trace_pkg::instr_word_u           done_instr,
  output logic [trace_pkg::class_w-1:0]    done_class,
  output logic [trace_pkg::reg_addr_w-1:0] done_rd,
  output logic                             done_rd_we,
  output logic [trace_pkg::xlen-1:0]       done_rd_value,
  output logic                             done_mem_valid,
  output logic                             done_mem_we,
  output logic [trace_pkg::xlen-1:0]       done_mem_addr,
  output logic [trace_pkg::cycle_w-1:0]    done_cycle
);

  import trace_pkg::*;

  logic                  ex_occ;
  logic                  ex_live;
  logic                  ex_adv;
  logic                  wb_occ;
  logic                  wb_hit;
  // EX slot
  logic [xlen-1:0]       ex_pc;
  instr_word_u           ex_instr;
  logic [class_w-1:0]    ex_class;
  logic [reg_addr_w-1:0] ex_rd;
  logic                  ex_rd_we;
  logic                  ex_mem;
  logic                  ex_mem_store;
  logic [cycle_w-1:0]    ex_cycle;
  logic [xlen-1:0]       ex_value;
  logic                  ex_acc_valid;
  logic                  ex_acc_we;
  logic [xlen-1:0]       ex_acc_addr;
  // EX contents for this cycle, strobes merged in
  logic [xlen-1:0]       cur_pc;
  instr_word_u           cur_instr;
  logic [class_w-1:0]    cur_class;
  logic [reg_addr_w-1:0] cur_rd;
  logic                  cur_rd_we;
  logic                  cur_mem;
  logic                  cur_mem_store;
  logic [cycle_w-1:0]    cur_cycle;
  logic [xlen-1:0]       cur_value;
  logic                  cur_acc_valid;
  logic                  cur_acc_we;
  logic [xlen-1:0]       cur_acc_addr;
  // WB slot
  logic                  wb_mem_store;
  logic [xlen-1:0]       wb_value;

  // a fresh capture counts as EX from its first cycle
  assign ex_live = cap_valid | ex_occ;
  assign ex_adv  = ex_live & (ex_valid | wb_bypass);

  //////////////////////////////
  // EX stage
  //////////////////////////////
  always_comb begin
    if (cap_valid) begin
      cur_pc        = cap_pc;
      cur_instr     = cap_instr;
      cur_class     = cap_class;
      cur_rd        = cap_rd;
      cur_rd_we     = cap_rd_we;
      cur_mem       = cap_mem;
      cur_mem_store = cap_mem_store;
      cur_cycle     = cap_cycle;
      cur_value     = '0;
      cur_acc_valid = 1'b0;
      cur_acc_we    = 1'b0;
      cur_acc_addr  = '0;
    end else begin
      cur_pc        = ex_pc;
      cur_instr     = ex_instr;
      cur_class     = ex_class;
      cur_rd        = ex_rd;
      cur_rd_we     = ex_rd_we;
      cur_mem       = ex_mem;
      cur_mem_store = ex_mem_store;
      cur_cycle     = ex_cycle;
      cur_value     = ex_value;
      cur_acc_valid = ex_acc_valid;
      cur_acc_we    = ex_acc_we;
      cur_acc_addr  = ex_acc_addr;
    end
    if (cur_rd_we && ex_reg_we && (ex_reg_addr == cur_rd)) begin
      cur_value = ex_reg_wdata;
    end
    // first grant wins
    if (cur_mem && !cur_acc_valid && ex_data_req && ex_data_gnt) begin
      cur_acc_valid = 1'b1;
      cur_acc_we    = ex_data_we;
      cur_acc_addr  = ex_data_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_live) begin
      ex_pc        <= cur_pc;
      ex_instr     <= cur_instr;
      ex_class     <= cur_class;
      ex_rd        <= cur_rd;
      ex_rd_we     <= cur_rd_we;
      ex_mem       <= cur_mem;
      ex_mem_store <= cur_mem_store;
      ex_cycle     <= cur_cycle;
      ex_value     <= cur_value;
      ex_acc_valid <= cur_acc_valid;
      ex_acc_we    <= cur_acc_we;
      ex_acc_addr  <= cur_acc_addr;
    end
  end

  //////////////////////////////
  // WB stage
  //////////////////////////////
  assign wb_hit = wb_occ && done_rd_we && wb_reg_we && (wb_reg_addr == done_rd);

  always_ff @(posedge clk) begin
    if (ex_adv) begin
      done_pc        <= cur_pc;
      done_instr     <= cur_instr;
      done_class     <= cur_class;
      done_rd        <= cur_rd;
      done_rd_we     <= cur_rd_we;
      wb_mem_store   <= cur_mem_store;
      done_cycle     <= cur_cycle;
      wb_value       <= cur_value;
      done_mem_valid <= cur_acc_valid;
      done_mem_we    <= cur_acc_we;
      done_mem_addr  <= cur_acc_addr;
    end else if (wb_hit) begin
      wb_value <= wb_reg_wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_occ <= 1'b0;
      wb_occ <= 1'b0;
    end else begin
      ex_occ <= ex_live & ~ex_adv;
      wb_occ <= ex_adv | (wb_occ & ~wb_valid);
    end
  end

  // retiring writeback overrides the stored value
  assign done_valid    = wb_occ & wb_valid;
  assign done_rd_value = wb_hit ? wb_reg_wdata : wb_value;

  a_ex_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) cap_valid |-> !ex_occ
  );

  a_wb_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) ex_adv |-> !(wb_occ && !wb_valid)
  );

  // access direction seen on the bus agrees with the decoded class
  a_store_dir: assert property (
    @(posedge clk) disable iff (!rst_n)
    done_valid && done_mem_valid |-> done_mem_we == wb_mem_store
  );

endmodule

`default_nettype wire

// ==== hdl/trace_record_out.sv ====
// retire_count wraps after 2**32 records; record fields are valid only with retire_valid
`default_nettype none

module trace_record_out (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             done_valid,
  input  logic [trace_pkg::xlen-1:0]       done_pc,
  input  logic [trace_pkg::xlen-1:0]       done_instr,
  input  logic [trace_pkg::class_w-1:0]    done_class,
  input  logic [trace_pkg::reg_addr_w-1:0] done_rd,
  input  logic                             done_rd_we,
  input  logic [trace_pkg::xlen-1:0]       done_rd_value,
  input  logic                             done_mem_valid,
  input  logic                             done_mem_we,
  input  logic [trace_pkg::xlen-1:0]       done_mem_addr,
  input  logic [trace_pkg::cycle_w-1:0]    done_cycle,
  output logic                             retire_valid,
  output logic [trace_pkg::xlen-1:0]       retire_pc,
  output logic [trace_pkg::xlen-1:0]       retire_instr,
  output logic [trace_pkg::class_w-1:0]    retire_class,
  output logic [trace_pkg::reg_addr_w-1:0] retire_rd,
  output logic                             retire_rd_we,
  output logic [trace_pkg::xlen-1:0]       retire_rd_value,
  output logic                             retire_mem_valid,
  output logic                             retire_mem_we,
  output logic [trace_pkg::xlen-1:0]       retire_mem_addr,
  output logic [trace_pkg::cycle_w-1:0]    retire_cycle,
  output logic [trace_pkg::cycle_w-1:0]    retire_count
);

  import trace_pkg::*;

  // pulse and counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      retire_count <= '0;
    end else begin
      retire_valid <= done_valid;
      if (done_valid) begin
        retire_count <= retire_count + 1'b1;
      end
    end
  end

  // record held until the next retire
  always_ff @(posedge clk) begin
    if (done_valid) begin
      retire_pc        <= done_pc;
      retire_instr     <= done_instr;
      retire_class     <= done_class;
      retire_rd        <= done_rd;
      retire_rd_we     <= done_rd_we;
      retire_rd_value  <= done_rd_value;
      retire_mem_valid <= done_mem_valid;
      retire_mem_we    <= done_mem_we;
      retire_mem_addr  <= done_mem_addr;
      retire_cycle     <= done_cycle;
    end
  end

  // access capture is gated by the class decoded at capture
  a_mem_class: assert property (
    @(posedge clk) disable iff (!rst_n)
    retire_valid && retire_mem_valid |-> class_is_mem(retire_class)
  );

endmodule

`default_nettype wire

// ==== hdl/instr_tracer.sv ====
// the core must not decode into a held EX slot; there is no back-pressure toward the core
`default_nettype none

module instr_tracer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [trace_pkg::xlen-1:0]       pc,
  input  logic [trace_pkg::xlen-1:0]       instr,
  input  logic                             id_valid,
  input  logic                             is_decoding,
  input  logic                             ex_valid,
  input  logic [trace_pkg::reg_addr_w-1:0] ex_reg_addr,
  input  logic                             ex_reg_we,
  input  logic [trace_pkg::xlen-1:0]       ex_reg_wdata,
  input  logic                             ex_data_req,
  input  logic                             ex_data_gnt,
  input  logic                             ex_data_we,
  input  logic [trace_pkg::xlen-1:0]       ex_data_addr,
  input  logic                             wb_bypass,
  input  logic                             wb_valid,
  input  logic [trace_pkg::reg_addr_w-1:0] wb_reg_addr,
  input  logic                             wb_reg_we,
  input  logic [trace_pkg::xlen-1:0]       wb_reg_wdata,
  output logic                             retire_valid,
  output logic [trace_pkg::xlen-1:0]       retire_pc,
  output logic [trace_pkg::xlen-1:0]       retire_instr,
  output logic [trace_pkg::class_w-1:0]    retire_class,
  output logic [trace_pkg::reg_addr_w-1:0] retire_rd,
  output logic                             retire_rd_we,
  output logic [trace_pkg::xlen-1:0]       retire_rd_value,
  output logic                             retire_mem_valid,
  output logic                             retire_mem_we,
  output logic [trace_pkg::xlen-1:0]       retire_mem_addr,
  output logic [trace_pkg::cycle_w-1:0]    retire_cycle,
  output logic [trace_pkg::cycle_w-1:0]    retire_count
);

  import trace_pkg::*;

  // capture to EX slot
  logic                  cap_valid;
  logic [xlen-1:0]       cap_pc;
  instr_word_u           cap_instr;
  logic [class_w-1:0]    cap_class;
  logic [reg_addr_w-1:0] cap_rd;
  logic                  cap_rd_we;
  logic                  cap_mem;
  logic                  cap_mem_store;
  logic [cycle_w-1:0]    cap_cycle;
  // WB slot to output register
  logic                  done_valid;
  logic [xlen-1:0]       done_pc;
  instr_word_u           done_instr;
  logic [class_w-1:0]    done_class;
  logic [reg_addr_w-1:0] done_rd;
  logic                  done_rd_we;
  logic [xlen-1:0]       done_rd_value;
  logic                  done_mem_valid;
  logic                  done_mem_we;
  logic [xlen-1:0]       done_mem_addr;
  logic [cycle_w-1:0]    done_cycle;

  trace_capture u_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc            (pc),
    .instr         (instr),
    .id_valid      (id_valid),
    .is_decoding   (is_decoding),
    .cap_valid     (cap_valid),
    .cap_pc        (cap_pc),
    .cap_instr     (cap_instr),
    .cap_class     (cap_class),
    .cap_rd        (cap_rd),
    .cap_rd_we     (cap_rd_we),
    .cap_mem       (cap_mem),
    .cap_mem_store (cap_mem_store),
    .cap_cycle     (cap_cycle)
  );

  trace_stage_track u_stage_track (
    .clk            (clk),
    .rst_n          (rst_n),
    .cap_valid      (cap_valid),
    .cap_pc         (cap_pc),
    .cap_instr      (cap_instr),
    .cap_class      (cap_class),
    .cap_rd         (cap_rd),
    .cap_rd_we      (cap_rd_we),
    .cap_mem        (cap_mem),
    .cap_mem_store  (cap_mem_store),
    .cap_cycle      (cap_cycle),
    .ex_valid       (ex_valid),
    .ex_reg_addr    (ex_reg_addr),
    .ex_reg_we      (ex_reg_we),
    .ex_reg_wdata   (ex_reg_wdata),
    .ex_data_req    (ex_data_req),
    .ex_data_gnt    (ex_data_gnt),
    .ex_data_we     (ex_data_we),
    .ex_data_addr   (ex_data_addr),
    .wb_bypass      (wb_bypass),
    .wb_valid       (wb_valid),
    .wb_reg_addr    (wb_reg_addr),
    .wb_reg_we      (wb_reg_we),
    .wb_reg_wdata   (wb_reg_wdata),
    .done_valid     (done_valid),
    .done_pc        (done_pc),
    .done_instr     (done_instr),
    .done_class     (done_class),
    .done_rd        (done_rd),
    .done_rd_we     (done_rd_we),
    .done_rd_value  (done_rd_value),
    .done_mem_valid (done_mem_valid),
    .done_mem_we    (done_mem_we),
    .done_mem_addr  (done_mem_addr),
    .done_cycle     (done_cycle)
  );

  trace_record_out u_record_out (
    .clk              (clk),
    .rst_n            (rst_n),
    .done_valid       (done_valid),
    .done_pc          (done_pc),
    .done_instr       (done_instr),
    .done_class       (done_class),
    .done_rd          (done_rd),
    .done_rd_we       (done_rd_we),
    .done_rd_value    (done_rd_value),
    .done_mem_valid   (done_mem_valid),
    .done_mem_we      (done_mem_we),
    .done_mem_addr    (done_mem_addr),
    .done_cycle       (done_cycle),
    .retire_valid     (retire_valid),
    .retire_pc        (retire_pc),
    .retire_instr     (retire_instr),
    .retire_class     (retire_class),
    .retire_rd        (retire_rd),
    .retire_rd_we     (retire_rd_we),
    .retire_rd_value  (retire_rd_value),
    .retire_mem_valid (retire_mem_valid),
    .retire_mem_we    (retire_mem_we),
    .retire_mem_addr  (retire_mem_addr),
    .retire_cycle     (retire_cycle),
    .retire_count     (retire_count)
  );

endmodule

`default_nettype wire

// ==== include/trace_vectors.svh ====
// rows need add_row from the including module; load rows use dwe 0 and store rows dwe 1
`ifndef TRACE_VECTORS_SVH
`define TRACE_VECTORS_SVH

//////////////////////////////
// one row per instruction, in program order
//////////////////////////////
// columns: pc, instr, ex_wait, wb_wait, bypass,
//   ex_addr, ex_data, wb_addr, wb_data, req, gnt, dwe, daddr, class, rd_we
task automatic build_table;
  // upper, wb data beats ex data
  add_row(32'h100, 32'h123452b7, 0, 0, 0,
          5'd5, 32'h12345000, 5'd5, 32'ha5a50000, 0, 0, 0, 32'h0, cls_upper, 1);
  add_row(32'h104, 32'h00000017, 1, 0, 0,
          5'd0, 32'h11, 5'd0, 32'h22, 0, 0, 0, 32'h0, cls_upper, 0);
  // jal through the bypass, wb address misses
  add_row(32'h108, 32'h008000ef, 0, 1, 1,
          5'd1, 32'h10c, 5'd3, 32'hdead, 0, 0, 0, 32'h0, cls_jump, 1);
  add_row(32'h110, 32'h00008067, 2, 0, 0,
          5'd0, 32'h0, 5'd0, 32'h0, 0, 0, 0, 32'h0, cls_jump, 0);
  add_row(32'h10c, 32'h00208463, 0, 2, 0,
          5'd2, 32'h55, 5'd2, 32'h66, 0, 0, 0, 32'h0, cls_branch, 0);
  // loads
  add_row(32'h114, 32'h00412303, 1, 1, 0,
          5'd6, 32'h1111, 5'd6, 32'h2222, 1, 1, 0, 32'h1000, cls_load, 1);
  add_row(32'h118, 32'h00014383, 0, 0, 1,
          5'd9, 32'h9999, 5'd7, 32'h7f, 1, 1, 0, 32'h2003, cls_load, 1);
  add_row(32'h11c, 32'h00013403, 0, 0, 0,
          5'd8, 32'h8888, 5'd8, 32'h8889, 1, 1, 0, 32'h2100, cls_invalid, 0);
  // stores, first grant over three EX cycles
  add_row(32'h120, 32'h00512423, 2, 0, 0,
          5'd8, 32'h0, 5'd8, 32'h0, 1, 1, 1, 32'h3008, cls_store, 0);
  add_row(32'h124, 32'h00010023, 1, 0, 0,
          5'd0, 32'h0, 5'd0, 32'h0, 1, 0, 1, 32'h3100, cls_store, 0);
  add_row(32'h128, 32'h00513423, 0, 1, 0,
          5'd8, 32'h0, 5'd8, 32'h0, 1, 1, 1, 32'h3200, cls_invalid, 0);
  // alu
  add_row(32'h12c, 32'h00100513, 0, 0, 0,
          5'd10, 32'h1, 5'd10, 32'h1, 0, 0, 0, 32'h0, cls_alu_imm, 1);
  add_row(32'h130, 32'h00a505b3, 0, 2, 1,
          5'd11, 32'h2, 5'd12, 32'h77, 0, 0, 0, 32'h0, cls_alu_reg, 1);
  add_row(32'h134, 32'h0ff0000f, 1, 0, 0,
          5'd0, 32'h0, 5'd0, 32'h0, 0, 0, 0, 32'h0, cls_fence, 0);
  // system
  add_row(32'h138, 32'h30051673, 0, 1, 0,
          5'd3, 32'h33, 5'd12, 32'h1800, 0, 0, 0, 32'h0, cls_csr, 1);
  add_row(32'h13c, 32'h00000073, 0, 0, 0,
          5'd0, 32'h0, 5'd0, 32'h0, 0, 0, 0, 32'h0, cls_system, 0);
  add_row(32'h140, 32'h0000007f, 0, 0, 0,
          5'd0, 32'h0, 5'd0, 32'h0, 1, 1, 0, 32'h4000, cls_invalid, 0);
endtask

`endif

// ==== verification/tb_instr_tracer.sv ====
// single driver process; rows are scheduled so that no slot overflows
`default_nettype none

module tb_instr_tracer;

  import trace_pkg::*;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [1:0]  ex_wait;
    logic [1:0]  wb_wait;
    logic        bypass;
    logic [4:0]  ex_addr;
    logic [31:0] ex_data;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        req;
    logic        gnt;
    logic        dwe;
    logic [31:0] daddr;
    logic [3:0]  exp_class;
    logic        exp_rd_we;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        id_valid;
  logic        is_decoding;
  logic        ex_valid;
  logic [4:0]  ex_reg_addr;
  logic        ex_reg_we;
  logic [31:0] ex_reg_wdata;
  logic        ex_data_req;
  logic        ex_data_gnt;
  logic        ex_data_we;
  logic [31:0] ex_data_addr;
  logic        wb_bypass;
  logic        wb_valid;
  logic [4:0]  wb_reg_addr;
  logic        wb_reg_we;
  logic [31:0] wb_reg_wdata;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [31:0] retire_instr;
  logic [3:0]  retire_class;
  logic [4:0]  retire_rd;
  logic        retire_rd_we;
  logic [31:0] retire_rd_value;
  logic        retire_mem_valid;
  logic        retire_mem_we;
  logic [31:0] retire_mem_addr;
  logic [31:0] retire_cycle;
  logic [31:0] retire_count;

  row_t        rows[$];
  int          pending[$];
  logic [31:0] exp_stamp[64];
  int          t_dec[64];
  int          t_adv[64];
  int          t_ret[64];
  int          seen;
  int          tb_cycle;
  int          watchdog;
  int          seed;

  instr_tracer u_instr_tracer (.*);

  task automatic add_row(input logic [31:0] p, input logic [31:0] w, input int exw,
                         input int wbw, input bit byp, input logic [4:0] exa,
                         input logic [31:0] exd, input logic [4:0] wba,
                         input logic [31:0] wbd, input bit rq, input bit gt, input bit dw,
                         input logic [31:0] da, input logic [3:0] cls, input bit we);
    row_t r;
    r = '{p, w, exw[1:0], wbw[1:0], byp, exa, exd, wba, wbd, rq, gt, dw, da, cls, we};
    rows.push_back(r);
  endtask

`include "trace_vectors.svh"

  task automatic report_mismatch(input string what);
    $display("[FAIL] %0t %s", $time, what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reference for the decode stamp that reads zero in the first cycle out of reset
  always @(posedge clk) begin
    if (rst_n) begin
      tb_cycle <= tb_cycle + 1;
    end
  end

  //////////////////////////////
  // timeout
  //////////////////////////////
  always @(posedge clk) begin
    watchdog <= watchdog + 1;
    if (watchdog > rows.size() * 12 + 40) begin
      $display("retirement stalled: only %0d of %0d records seen", seen, rows.size());
      $display("Some tests failed");
      $fatal(1);
    end
  end

  //////////////////////////////
  // checker
  //////////////////////////////
  always @(posedge clk) begin
    row_t        r;
    instr_word_u w;
    int          idx;
    logic        exp_mem;
    if (seen == 0 && !retire_valid) begin
      assert (retire_count == 0) else report_mismatch("retire_count nonzero before retire");
    end
    if (retire_valid) begin
      assert (pending.size() > 0) else report_mismatch("retire with nothing in flight");
      idx = pending.pop_front();
      r = rows[idx];
      w = r.instr;
      exp_mem = r.req && r.gnt && (r.exp_class == cls_load || r.exp_class == cls_store);
      assert (retire_pc == r.pc) else report_mismatch("pc out of order");
      assert (retire_instr == r.instr) else report_mismatch("instr mismatch");
      assert (retire_class == r.exp_class) else report_mismatch("class mismatch");
      assert (retire_rd == w.r.rd) else report_mismatch("rd mismatch");
      assert (retire_rd_we == r.exp_rd_we) else report_mismatch("rd_we mismatch");
      if (r.exp_rd_we && r.wb_addr == w.r.rd) begin
        assert (retire_rd_value == r.wb_data) else report_mismatch("wb value mismatch");
      end else if (r.exp_rd_we && r.ex_addr == w.r.rd) begin
        assert (retire_rd_value == r.ex_data) else report_mismatch("ex value mismatch");
      end
      assert (retire_mem_valid == exp_mem) else report_mismatch("mem_valid mismatch");
      if (exp_mem) begin
        assert (retire_mem_we == r.dwe) else report_mismatch("mem_we mismatch");
        assert (retire_mem_addr == r.daddr) else report_mismatch("mem_addr mismatch");
      end
      assert (retire_cycle == exp_stamp[idx]) else report_mismatch("cycle stamp mismatch");
      assert (retire_count == seen + 1) else report_mismatch("retire_count mismatch");
      seen <= seen + 1;
    end
  end

  //////////////////////////////
  // driver
  //////////////////////////////
  initial begin
    int          last;
    int          prev_ret;
    logic        v_id;
    logic        v_dec;
    logic [31:0] v_pc;
    logic [31:0] v_instr;
    logic        v_exv;
    logic        v_byp;
    logic        v_exwe;
    logic [4:0]  v_exa;
    logic [31:0] v_exd;
    logic        v_req;
    logic        v_gnt;
    logic        v_dwe;
    logic [31:0] v_da;
    logic        v_wbv;
    logic        v_wbwe;
    logic [4:0]  v_wba;
    logic [31:0] v_wbd;
    seed = 32'hefe7;
    seen = 0;
    tb_cycle = 0;
    watchdog = 0;
    rst_n <= 1'b0;
    pc <= '0;
    instr <= '0;
    id_valid <= 1'b0;
    is_decoding <= 1'b0;
    ex_valid <= 1'b0;
    ex_reg_addr <= '0;
    ex_reg_we <= 1'b0;
    ex_reg_wdata <= '0;
    ex_data_req <= 1'b0;
    ex_data_gnt <= 1'b0;
    ex_data_we <= 1'b0;
    ex_data_addr <= '0;
    wb_bypass <= 1'b0;
    wb_valid <= 1'b0;
    wb_reg_addr <= '0;
    wb_reg_we <= 1'b0;
    wb_reg_wdata <= '0;
    build_table();
    // next decode shares the cycle in which the previous row leaves EX
    prev_ret = -1;
    for (int i = 0; i < rows.size(); i++) begin
      t_dec[i] = (i == 0) ? 0 : t_adv[i-1];
      t_adv[i] = t_dec[i] + 1 + rows[i].ex_wait;
      if (t_adv[i] < prev_ret) begin
        t_adv[i] = prev_ret;
      end
      t_ret[i] = t_adv[i] + 1 + rows[i].wb_wait;
      prev_ret = t_ret[i];
    end
    last = prev_ret + 3;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int c = 0; c <= last; c++) begin
      @(posedge clk);
      // between decodes only one of the two decode strobes is high
      v_id = c[0];
      v_dec = !c[0];
      v_exv = 0;
      v_byp = 0;
      v_exwe = 0;
      v_req = 0;
      v_gnt = 0;
      v_dwe = 0;
      v_wbv = 0;
      v_wbwe = 0;
      v_pc = '0;
      v_instr = '0;
      v_exa = '0;
      v_wba = '0;
      v_exd = $random(seed);
      v_wbd = $random(seed);
      v_da = $random(seed);
      for (int i = 0; i < rows.size(); i++) begin
        if (c == t_dec[i]) begin
          v_id = 1;
          v_dec = 1;
          v_pc = rows[i].pc;
          v_instr = rows[i].instr;
          // decode is sampled at the next edge
          exp_stamp[i] = tb_cycle + 1;
          pending.push_back(i);
        end
        if (c > t_dec[i] && c <= t_adv[i]) begin
          if (c == t_dec[i] + 1) begin
            v_exwe = 1;
            v_exa = rows[i].ex_addr;
            v_exd = rows[i].ex_data;
          end
          v_req = rows[i].req;
          v_gnt = rows[i].gnt;
          v_dwe = rows[i].dwe;
          v_da = rows[i].daddr + 4 * (c - t_dec[i] - 1);
          if (c == t_adv[i]) begin
            v_exv = !rows[i].bypass;
            v_byp = rows[i].bypass;
          end
        end
        if (c == t_ret[i]) begin
          v_wbv = 1;
          v_wbwe = 1;
          v_wba = rows[i].wb_addr;
          v_wbd = rows[i].wb_data;
        end
      end
      pc <= v_pc;
      instr <= v_instr;
      id_valid <= v_id;
      is_decoding <= v_dec;
      ex_valid <= v_exv;
      wb_bypass <= v_byp;
      ex_reg_we <= v_exwe;
      ex_reg_addr <= v_exa;
      ex_reg_wdata <= v_exd;
      ex_data_req <= v_req;
      ex_data_gnt <= v_gnt;
      ex_data_we <= v_dwe;
      ex_data_addr <= v_da;
      wb_valid <= v_wbv;
      wb_reg_we <= v_wbwe;
      wb_reg_addr <= v_wba;
      wb_reg_wdata <= v_wbd;
    end
    while (seen < rows.size()) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    if (seen == rows.size() && retire_count == rows.size()) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("[FAIL] %0t retire_count %0d after %0d records", $time, retire_count, seen);
      $display("Some tests failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/trace_pkg.sv
hdl/trace_capture.sv
hdl/trace_stage_track.sv
hdl/trace_record_out.sv
hdl/instr_tracer.sv
+incdir+include
verification/tb_instr_tracer.sv
